/* rtl/aximm_consts.svh */
// widths, memory depth and register offsets; include wherever these constants are used
`ifndef AXIMM_CONSTS_SVH
`define AXIMM_CONSTS_SVH

`define AXIMM_DATA_W     64
`define AXIMM_MEM_DEPTH  256
`define AXIMM_ADDR_W     8
`define AXIMM_LEN_W      8

// register byte offsets
`define CSR_CTRL       32'h00
`define CSR_ADDR       32'h04
`define CSR_LEN        32'h08
`define CSR_SEED       32'h0c
`define CSR_STATUS     32'h10
`define CSR_OUT_FIRST  32'h14
`define CSR_OUT_LAST   32'h18
`define CSR_IN_FIRST   32'h1c
`define CSR_IN_LAST    32'h20
`define CSR_ERR_COUNT  32'h24

`endif

/* rtl/aximm_pkg.sv */
// shared types and the burst pattern rule, imported by the loopback harness modules
`default_nettype none

`include "aximm_consts.svh"

package aximm_pkg;

	typedef logic [`AXIMM_DATA_W-1:0] data_t;
	typedef logic [`AXIMM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`AXIMM_LEN_W-1:0]  burst_len_t;
	typedef logic [31:0]              seed_t;
	typedef logic [31:0]              csr_word_t;
	typedef logic [15:0]              err_count_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_ADDR,
		ST_WR_DATA,
		ST_RD_ADDR,
		ST_RD_DATA
	} leader_state_t;

	typedef struct packed {
		logic       pass;
		logic       fail;
		err_count_t err_count;
		data_t      first;
		data_t      last;
	} check_result_t;

	// seed in the upper half, seed plus beat index in the lower half
	function automatic data_t pattern_beat(seed_t seed, burst_len_t idx);
		return {seed, seed + seed_t'(idx)};
	endfunction

endpackage

`default_nettype wire

/* rtl/axi_burst_if.sv */
// simplified AXI channels between leader and follower, and the test command bundle
`timescale 1ns/1ps
`default_nettype none

interface axi_burst_if import aximm_pkg::*; ();

	mem_addr_t  aw_addr;
	burst_len_t aw_len;
	logic       aw_valid;
	logic       aw_ready;

	data_t      w_data;
	logic       w_last;
	logic       w_valid;
	logic       w_ready;

	mem_addr_t  ar_addr;
	burst_len_t ar_len;
	logic       ar_valid;
	logic       ar_ready;

	data_t      r_data;
	logic       r_last;
	logic       r_valid;
	logic       r_ready;

	modport leader (
		output aw_addr, aw_len, aw_valid, w_data, w_last, w_valid,
		output ar_addr, ar_len, ar_valid, r_ready,
		input  aw_ready, w_ready, ar_ready, r_valid, r_last
	);

	modport follower (
		input  aw_addr, aw_len, aw_valid, w_data, w_last, w_valid,
		input  ar_addr, ar_len, ar_valid, r_ready,
		output aw_ready, w_ready, ar_ready, r_data, r_last, r_valid
	);

	modport monitor (
		input r_data, r_last, r_valid, r_ready, ar_valid, ar_ready
	);

endinterface

interface test_cmd_if import aximm_pkg::*; ();

	logic       wr_start;
	logic       rd_start;
	mem_addr_t  addr;
	burst_len_t len;
	seed_t      seed;

	logic       busy;
	logic       write_complete;
	logic       read_complete;
	data_t      out_first;
	data_t      out_last;

	modport csr (
		output wr_start, rd_start, addr, len, seed,
		input  busy, write_complete, read_complete, out_first, out_last
	);

	modport engine (
		input  wr_start, rd_start, addr, len, seed,
		output busy, write_complete, read_complete, out_first, out_last
	);

	modport monitor (
		input seed, len, rd_start
	);

endinterface

`default_nettype wire

/* rtl/test_csr.sv */
// register block of the harness: holds the test setup, issues starts, returns status
`timescale 1ns/1ps
`default_nettype none

`include "aximm_consts.svh"

module test_csr import aximm_pkg::*; (
	input  wire                 clk,
	input  wire                 i_reset,
	input  wire csr_word_t      i_address,
	input  wire csr_word_t      i_writedata,
	input  wire                 i_write,
	input  wire                 i_read,
	output csr_word_t           o_readdata,
	output logic                o_readdatavalid,
	output logic                o_waitrequest,
	test_cmd_if.csr             cmd,
	input  wire check_result_t  i_result,
	output logic [1:0]          o_test_done
);

	logic      ctrl_hit;
	logic      engine_busy;
	logic      write_ok;
	csr_word_t status;

	assign ctrl_hit    = (i_address == `CSR_CTRL);
	// a start already in the pipe counts as busy
	assign engine_busy = cmd.busy | cmd.wr_start | cmd.rd_start;

	assign o_waitrequest = i_write & ctrl_hit & engine_busy;
	assign write_ok      = i_write & ~o_waitrequest;

	assign status = csr_word_t'({i_result.fail, i_result.pass, cmd.busy,
		cmd.read_complete, cmd.write_complete});

	assign o_test_done = {i_result.fail, i_result.pass};

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_reset) begin
			cmd.addr <= '0;
			cmd.len  <= '0;
			cmd.seed <= '0;
		end else if (write_ok) begin
			case (i_address)
				`CSR_ADDR: cmd.addr <= mem_addr_t'(i_writedata);
				`CSR_LEN:  cmd.len  <= burst_len_t'(i_writedata);
				`CSR_SEED: cmd.seed <= i_writedata;
				default: ;
			endcase
		end
	end

	// write wins when both ctrl bits are set
	always_ff @(posedge clk) begin
		if (i_reset) begin
			cmd.wr_start <= 1'b0;
			cmd.rd_start <= 1'b0;
		end else begin
			cmd.wr_start <= write_ok & ctrl_hit & i_writedata[0];
			cmd.rd_start <= write_ok & ctrl_hit & i_writedata[1] & ~i_writedata[0];
		end
	end

	////////////////////////////////////////////////////////////
	// read side, data one cycle after i_read
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_reset)
			o_readdatavalid <= 1'b0;
		else
			o_readdatavalid <= i_read;
	end

	always_ff @(posedge clk) begin
		if (i_read) begin
			case (i_address)
				`CSR_ADDR:      o_readdata <= csr_word_t'(cmd.addr);
				`CSR_LEN:       o_readdata <= csr_word_t'(cmd.len);
				`CSR_SEED:      o_readdata <= cmd.seed;
				`CSR_STATUS:    o_readdata <= status;
				`CSR_OUT_FIRST: o_readdata <= cmd.out_first[31:0];
				`CSR_OUT_LAST:  o_readdata <= cmd.out_last[31:0];
				`CSR_IN_FIRST:  o_readdata <= i_result.first[31:0];
				`CSR_IN_LAST:   o_readdata <= i_result.last[31:0];
				`CSR_ERR_COUNT: o_readdata <= csr_word_t'(i_result.err_count);
				default:        o_readdata <= '0;
			endcase
		end
	end

	// the engine must be idle whenever a start is pulsed
	a_start_when_idle: assert property (@(posedge clk) disable iff (i_reset)
		(cmd.wr_start || cmd.rd_start) |-> !cmd.busy);

endmodule

`default_nettype wire

/* rtl/burst_leader.sv */
// burst engine: writes a patterned burst to the follower, or requests a read-back
`timescale 1ns/1ps
`default_nettype none

module burst_leader import aximm_pkg::*; (
	input  wire          clk,
	input  wire          i_reset,
	test_cmd_if.engine   cmd,
	axi_burst_if.leader  axi
);

	leader_state_t state;
	mem_addr_t     addr_q;
	burst_len_t    len_q;
	seed_t         seed_q;
	burst_len_t    beat;
	logic          start;
	logic          aw_fire;
	logic          w_fire;
	logic          ar_fire;
	logic          r_fire;

	assign start   = cmd.wr_start | cmd.rd_start;
	assign aw_fire = axi.aw_valid & axi.aw_ready;
	assign w_fire  = axi.w_valid & axi.w_ready;
	assign ar_fire = axi.ar_valid & axi.ar_ready;
	assign r_fire  = axi.r_valid & axi.r_ready;

	assign axi.aw_addr = addr_q;
	assign axi.aw_len  = len_q;
	assign axi.ar_addr = addr_q;
	assign axi.ar_len  = len_q;
	assign axi.w_data  = pattern_beat(seed_q, beat);
	assign axi.w_last  = (beat == len_q);

	assign cmd.busy = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state              <= ST_IDLE;
			axi.aw_valid       <= 1'b0;
			axi.w_valid        <= 1'b0;
			axi.ar_valid       <= 1'b0;
			axi.r_ready        <= 1'b0;
			cmd.write_complete <= 1'b0;
			cmd.read_complete  <= 1'b0;
			beat               <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd.wr_start) begin
						state              <= ST_WR_ADDR;
						axi.aw_valid       <= 1'b1;
						cmd.write_complete <= 1'b0;
					end else if (cmd.rd_start) begin
						state             <= ST_RD_ADDR;
						axi.ar_valid      <= 1'b1;
						cmd.read_complete <= 1'b0;
					end
				end
				ST_WR_ADDR: begin
					if (aw_fire) begin
						state        <= ST_WR_DATA;
						axi.aw_valid <= 1'b0;
						axi.w_valid  <= 1'b1;
						beat         <= '0;
					end
				end
				ST_WR_DATA: begin
					if (w_fire) begin
						beat <= beat + 1'b1;
						if (axi.w_last) begin
							state              <= ST_IDLE;
							axi.w_valid        <= 1'b0;
							cmd.write_complete <= 1'b1;
						end
					end
				end
				ST_RD_ADDR: begin
					if (ar_fire) begin
						state        <= ST_RD_DATA;
						axi.ar_valid <= 1'b0;
						axi.r_ready  <= 1'b1;
					end
				end
				ST_RD_DATA: begin
					// ready stays up, the checker sees every beat
					if (r_fire && axi.r_last) begin
						state             <= ST_IDLE;
						axi.r_ready       <= 1'b0;
						cmd.read_complete <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command latch and first/last written beats
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			addr_q <= cmd.addr;
			len_q  <= cmd.len;
			seed_q <= cmd.seed;
		end
		if (w_fire && beat == '0)
			cmd.out_first <= axi.w_data;
		if (w_fire && axi.w_last)
			cmd.out_last <= axi.w_data;
	end

	a_wvalid_in_wdata: assert property (@(posedge clk) disable iff (i_reset)
		axi.w_valid |-> state == ST_WR_DATA);

endmodule

`default_nettype wire

/* rtl/follower_mem.sv */
// AXI follower with a 256-word memory; writes bursts in, streams bursts out
`timescale 1ns/1ps
`default_nettype none

`include "aximm_consts.svh"

module follower_mem import aximm_pkg::*; (
	input  wire            clk,
	input  wire            i_reset,
	axi_burst_if.follower  axi
);

	data_t      mem [`AXIMM_MEM_DEPTH];
	mem_addr_t  wr_ptr;
	mem_addr_t  rd_ptr;
	burst_len_t wr_cnt;
	burst_len_t wr_len;
	burst_len_t rd_cnt;
	burst_len_t rd_len;
	logic       wr_active;
	logic       rd_active;
	logic       rd_busy;
	data_t      s1_data;
	logic       s1_valid;
	logic       s1_last;
	logic       aw_fire;
	logic       w_fire;
	logic       ar_fire;
	logic       r_fire;
	logic       out_free;
	logic       s1_move;
	logic       issue;

	// one burst at a time, write address first
	assign rd_busy      = rd_active | s1_valid | axi.r_valid;
	assign axi.aw_ready = ~wr_active & ~rd_busy;
	assign axi.ar_ready = ~wr_active & ~rd_busy & ~axi.aw_valid;
	assign axi.w_ready  = wr_active;

	assign aw_fire = axi.aw_valid & axi.aw_ready;
	assign w_fire  = axi.w_valid & axi.w_ready;
	assign ar_fire = axi.ar_valid & axi.ar_ready;
	assign r_fire  = axi.r_valid & axi.r_ready;

	// read pipe: memory register s1, then the r output register
	assign out_free = ~axi.r_valid | r_fire;
	assign s1_move  = s1_valid & out_free;
	assign issue    = rd_active & (~s1_valid | s1_move);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_active   <= 1'b0;
			rd_active   <= 1'b0;
			s1_valid    <= 1'b0;
			axi.r_valid <= 1'b0;
		end else begin
			if (aw_fire) begin
				wr_active <= 1'b1;
				wr_ptr    <= axi.aw_addr;
				wr_cnt    <= '0;
				wr_len    <= axi.aw_len;
			end else if (w_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
				wr_cnt <= wr_cnt + 1'b1;
				if (axi.w_last)
					wr_active <= 1'b0;
			end
			if (ar_fire) begin
				rd_active <= 1'b1;
				rd_ptr    <= axi.ar_addr;
				rd_cnt    <= '0;
				rd_len    <= axi.ar_len;
			end else if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == rd_len)
					rd_active <= 1'b0;
			end
			if (issue)
				s1_valid <= 1'b1;
			else if (s1_move)
				s1_valid <= 1'b0;
			if (s1_move)
				axi.r_valid <= 1'b1;
			else if (r_fire)
				axi.r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (w_fire)
			mem[wr_ptr] <= axi.w_data;
		if (issue) begin
			s1_data <= mem[rd_ptr];
			s1_last <= (rd_cnt == rd_len);
		end
		if (s1_move) begin
			axi.r_data <= s1_data;
			axi.r_last <= s1_last;
		end
	end

	a_wlast_on_final: assert property (@(posedge clk) disable iff (i_reset)
		w_fire |-> (axi.w_last == (wr_cnt == wr_len)));

endmodule

`default_nettype wire

/* rtl/pattern_checker.sv */
// checks read-back beats against the regenerated pattern and holds pass/fail
`timescale 1ns/1ps
`default_nettype none

module pattern_checker import aximm_pkg::*; (
	input  wire            clk,
	input  wire            i_reset,
	test_cmd_if.monitor    cmd,
	axi_burst_if.monitor   axi,
	output check_result_t  o_result
);

	seed_t      seed_q;
	burst_len_t len_q;
	burst_len_t beat;
	logic       armed;
	logic       pass_q;
	logic       fail_q;
	err_count_t err_q;
	err_count_t err_next;
	data_t      first_q;
	data_t      last_q;
	logic       r_fire;
	logic       mismatch;

	assign r_fire   = armed & axi.r_valid & axi.r_ready;
	// a misplaced last counts as an error too
	assign mismatch = (axi.r_data != pattern_beat(seed_q, beat)) ||
		(axi.r_last != (beat == len_q));
	assign err_next = err_q + err_count_t'(mismatch);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			armed  <= 1'b0;
			pass_q <= 1'b0;
			fail_q <= 1'b0;
			err_q  <= '0;
			beat   <= '0;
		end else if (cmd.rd_start) begin
			armed  <= 1'b0;
			pass_q <= 1'b0;
			fail_q <= 1'b0;
			err_q  <= '0;
			beat   <= '0;
			seed_q <= cmd.seed;
			len_q  <= cmd.len;
		end else begin
			if (axi.ar_valid && axi.ar_ready)
				armed <= 1'b1;
			if (r_fire) begin
				err_q <= err_next;
				beat  <= beat + 1'b1;
				if (axi.r_last) begin
					armed  <= 1'b0;
					pass_q <= (err_next == '0);
					fail_q <= (err_next != '0);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire && beat == '0)
			first_q <= axi.r_data;
		if (r_fire && axi.r_last)
			last_q <= axi.r_data;
	end

	assign o_result.pass      = pass_q;
	assign o_result.fail      = fail_q;
	assign o_result.err_count = err_q;
	assign o_result.first     = first_q;
	assign o_result.last      = last_q;

endmodule

`default_nettype wire

/* rtl/aximm_loopback_top.sv */
// top level of the AXI loopback harness; register port in, pass/fail out
`timescale 1ns/1ps
`default_nettype none

module aximm_loopback_top import aximm_pkg::*; (
	input  wire             clk,
	input  wire             i_reset,
	input  wire csr_word_t  i_address,
	input  wire csr_word_t  i_writedata,
	input  wire             i_write,
	input  wire             i_read,
	output csr_word_t       o_readdata,
	output logic            o_readdatavalid,
	output logic            o_waitrequest,
	output logic [1:0]      o_test_done
);

	axi_burst_if axi0 ();
	test_cmd_if  cmd0 ();

	check_result_t result;

	test_csr u_test_csr (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_address       (i_address),
		.i_writedata     (i_writedata),
		.i_write         (i_write),
		.i_read          (i_read),
		.o_readdata      (o_readdata),
		.o_readdatavalid (o_readdatavalid),
		.o_waitrequest   (o_waitrequest),
		.cmd             (cmd0.csr),
		.i_result        (result),
		.o_test_done     (o_test_done)
	);

	burst_leader u_burst_leader (
		.clk     (clk),
		.i_reset (i_reset),
		.cmd     (cmd0.engine),
		.axi     (axi0.leader)
	);

	follower_mem u_follower_mem (
		.clk     (clk),
		.i_reset (i_reset),
		.axi     (axi0.follower)
	);

	pattern_checker u_pattern_checker (
		.clk      (clk),
		.i_reset  (i_reset),
		.cmd      (cmd0.monitor),
		.axi      (axi0.monitor),
		.o_result (result)
	);

endmodule

`default_nettype wire

/* bench/aximm_loopback_tb.sv */
// testbench for the AXI loopback harness; runs the tests listed in bench/loopback_patterns.txt
`timescale 1ns/1ps
`default_nettype none

`include "aximm_consts.svh"

module aximm_loopback_tb import aximm_pkg::*; ();

	localparam int WRITE_WAIT_LIMIT = 1000;
	localparam int POLL_LIMIT       = 400;

	logic        clk;
	logic        i_reset;
	csr_word_t   i_address;
	csr_word_t   i_writedata;
	logic        i_write;
	logic        i_read;
	csr_word_t   o_readdata;
	logic        o_readdatavalid;
	logic        o_waitrequest;
	logic [1:0]  o_test_done;

	// what the follower memory should hold
	data_t       mem_model [`AXIMM_MEM_DEPTH];
	logic [31:0] lfsr;

	aximm_loopback_top dut0 (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_address       (i_address),
		.i_writedata     (i_writedata),
		.i_write         (i_write),
		.i_read          (i_read),
		.o_readdata      (o_readdata),
		.o_readdatavalid (o_readdatavalid),
		.o_waitrequest   (o_waitrequest),
		.o_test_done     (o_test_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// upper half the seed, lower half seed plus beat index
	function automatic data_t expected_beat(seed_t seed, int idx);
		seed_t low;
		low = seed + seed_t'(idx);
		return {seed, low};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input csr_word_t exp, input csr_word_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic compare_flags(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic compare_count(input string name, input err_count_t exp,
		input err_count_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	////////////////////////////////////////////////////////////
	// register port
	////////////////////////////////////////////////////////////

	task automatic reg_write(input csr_word_t addr, input csr_word_t data, output int waits);
		@(posedge clk);
		#1;
		i_write     = 1'b1;
		i_address   = addr;
		i_writedata = data;
		waits       = 0;
		#1;
		while (o_waitrequest) begin
			if (waits == WRITE_WAIT_LIMIT)
				abort_run($sformatf("timeout: write to 0x%h stayed in o_waitrequest", addr));
			@(posedge clk);
			#2;
			waits++;
		end
		@(posedge clk);
		#1;
		i_write = 1'b0;
	endtask

	task automatic reg_read(input csr_word_t addr, output csr_word_t data);
		@(posedge clk);
		#1;
		if (o_readdatavalid !== 1'b0)
			abort_run("o_readdatavalid was high with no read pending");
		i_read    = 1'b1;
		i_address = addr;
		@(posedge clk);
		#1;
		i_read = 1'b0;
		if (o_readdatavalid !== 1'b1)
			abort_run($sformatf("read of 0x%h did not return data one cycle later", addr));
		data = o_readdata;
	endtask

	task automatic wait_status(input csr_word_t mask, input string what);
		csr_word_t s;
		int        polls;
		int        gap;
		logic      seen;
		polls = 0;
		seen  = 1'b0;
		while (!seen) begin
			if (polls == POLL_LIMIT)
				abort_run($sformatf("timeout: %s never showed up in STATUS", what));
			reg_read(`CSR_STATUS, s);
			seen = ((s & mask) == mask);
			polls++;
			take_bits(2, gap);
			repeat (gap) @(posedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test steps
	////////////////////////////////////////////////////////////

	task automatic load_setup(input string name, input mem_addr_t addr, input burst_len_t len,
		input seed_t seed);
		int        waits;
		csr_word_t rd;
		reg_write(`CSR_ADDR, csr_word_t'(addr), waits);
		reg_write(`CSR_LEN, csr_word_t'(len), waits);
		reg_write(`CSR_SEED, seed, waits);
		reg_read(`CSR_ADDR, rd);
		compare_word({name, " addr"}, csr_word_t'(addr), rd);
		reg_read(`CSR_LEN, rd);
		compare_word({name, " len"}, csr_word_t'(len), rd);
		reg_read(`CSR_SEED, rd);
		compare_word({name, " seed"}, seed, rd);
	endtask

	task automatic check_write(input string name, input mem_addr_t addr,
		input burst_len_t len, input seed_t seed);
		csr_word_t rd;
		wait_status(32'h1, "write_complete");
		for (int i = 0; i <= int'(len); i++)
			mem_model[mem_addr_t'(addr + i)] = expected_beat(seed, i);
		reg_read(`CSR_OUT_FIRST, rd);
		compare_word({name, " out_first"}, seed, rd);
		reg_read(`CSR_OUT_LAST, rd);
		compare_word({name, " out_last"}, seed + seed_t'(len), rd);
	endtask

	task automatic check_read(input string name, input mem_addr_t addr,
		input burst_len_t len, input seed_t seed, input logic exp_pass);
		csr_word_t  rd;
		err_count_t exp_errs;
		mem_addr_t  last_addr;
		exp_errs  = '0;
		last_addr = addr + len;
		for (int i = 0; i <= int'(len); i++) begin
			if (mem_model[mem_addr_t'(addr + i)] !== expected_beat(seed, i))
				exp_errs++;
		end
		if ((exp_errs == 0) != exp_pass)
			abort_run({name, ": pass flag in the pattern file disagrees with the written data"});
		wait_status(32'h2, "read_complete");
		compare_flags({name, " test_done"}, exp_pass ? 2'b01 : 2'b10, o_test_done);
		reg_read(`CSR_IN_FIRST, rd);
		compare_word({name, " in_first"}, mem_model[addr][31:0], rd);
		reg_read(`CSR_IN_LAST, rd);
		compare_word({name, " in_last"}, mem_model[last_addr][31:0], rd);
		reg_read(`CSR_ERR_COUNT, rd);
		compare_count({name, " err_count"}, exp_errs, err_count_t'(rd));
	endtask

	task automatic run_test(input int lineno, input logic [31:0] op, input int addr,
		input int len, input seed_t seed, input int pass);
		string     name;
		int        waits;
		csr_word_t rd;
		if (op == "wr") begin
			name = $sformatf("line%0d_write", lineno);
			load_setup(name, mem_addr_t'(addr), burst_len_t'(len), seed);
			reg_write(`CSR_CTRL, 32'h1, waits);
			check_write(name, mem_addr_t'(addr), burst_len_t'(len), seed);
		end else if (op == "rd") begin
			name = $sformatf("line%0d_read", lineno);
			load_setup(name, mem_addr_t'(addr), burst_len_t'(len), seed);
			reg_write(`CSR_CTRL, 32'h2, waits);
			check_read(name, mem_addr_t'(addr), burst_len_t'(len), seed, pass != 0);
		end else if (op == "wb") begin
			name = $sformatf("line%0d_write_then_read", lineno);
			load_setup(name, mem_addr_t'(addr), burst_len_t'(len), seed);
			reg_write(`CSR_CTRL, 32'h1, waits);
			// second start lands while the write burst runs
			reg_write(`CSR_CTRL, 32'h2, waits);
			if (waits == 0)
				abort_run({name, ": CTRL write while busy was not held by o_waitrequest"});
			check_write(name, mem_addr_t'(addr), burst_len_t'(len), seed);
			check_read(name, mem_addr_t'(addr), burst_len_t'(len), seed, pass != 0);
			reg_read(`CSR_STATUS, rd);
			compare_word({name, " status"}, (pass != 0) ? 32'h0b : 32'h13, rd);
		end else begin
			abort_run($sformatf("line %0d of the pattern file has an unknown operation", lineno));
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int              fd;
		int              n;
		int              lineno;
		int              tests_run;
		int              addr;
		int              len;
		int              pass;
		seed_t           seed;
		logic [31:0]     op;
		logic [1023:0]   line;
		csr_word_t       rd;

		i_reset     = 1'b1;
		i_address   = '0;
		i_writedata = '0;
		i_write     = 1'b0;
		i_read      = 1'b0;
		lfsr        = 32'h2496;
		lineno      = 0;
		tests_run   = 0;

		repeat (2) @(posedge clk);
		#1;
		i_reset = 1'b0;

		// idle state straight after reset
		compare_flags("reset test_done", 2'b00, o_test_done);
		if (o_waitrequest !== 1'b0 || o_readdatavalid !== 1'b0)
			abort_run("o_waitrequest or o_readdatavalid active after reset");
		reg_read(`CSR_STATUS, rd);
		compare_word("reset status", 32'h0, rd);

		fd = $fopen("bench/loopback_patterns.txt", "r");
		if (fd == 0)
			abort_run("could not open bench/loopback_patterns.txt");
		while ($fgets(line, fd) != 0) begin
			lineno++;
			op = '0;
			n  = $sscanf(line, "%s %d %d %h %d", op, addr, len, seed, pass);
			if (n == 5) begin
				run_test(lineno, op, addr, len, seed, pass);
				tests_run++;
			end else if (op != "#" && op != '0) begin
				abort_run($sformatf("line %0d of the pattern file is malformed", lineno));
			end
		end
		$fclose(fd);

		if (tests_run == 0) begin
			$display("no tests were read from the pattern file");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/aximm_pkg.sv
rtl/axi_burst_if.sv
rtl/test_csr.sv
rtl/burst_leader.sv
rtl/follower_mem.sv
rtl/pattern_checker.sv
rtl/aximm_loopback_top.sv
bench/aximm_loopback_tb.sv

/* bench/loopback_patterns.txt */
# columns: op addr len seed pass (addr and len decimal, seed hex, pass 1 or 0)
# op: wr writes a burst, rd reads it back, wb writes then issues the read while busy
wr 16 7 00001000 1
rd 16 7 00001000 1
rd 16 7 0000abcd 0
rd 16 7 00001000 1
wr 250 15 5a5a0000 1
rd 250 15 5a5a0000 1
wr 0 0 deadbeef 1
rd 0 0 deadbeef 1
wb 100 31 fffffff0 1
rd 100 31 12345678 0
wr 120 255 00000001 1
rd 120 255 00000001 1
wb 64 3 0badf00d 1
